// File: rename_stage.f
logic/rename_pkg.sv
logic/rename_slot_if.sv
logic/free_list_queue.sv
logic/rename_slot.sv
logic/map_table.sv
logic/rename_stage.sv
verif/rename_stage_asserts.sv
verif/rename_stage_tb.sv

// File: verif/rename_stage_tb.sv
`timescale 1ns/100ps

module rename_stage_tb import rename_pkg::*; ();

    // ==========================================================
    // DUT signals
    // ==========================================================

    logic clk;
    logic reset;
    logic      [RENAME_WIDTH-1:0] decode_valid;
    logic      [RENAME_WIDTH-1:0] rd_we;
    arch_reg_t [RENAME_WIDTH-1:0] rs1_arch;
    arch_reg_t [RENAME_WIDTH-1:0] rs2_arch;
    arch_reg_t [RENAME_WIDTH-1:0] rd_arch;
    phys_reg_t [RENAME_WIDTH-1:0] rs1_phys;
    phys_reg_t [RENAME_WIDTH-1:0] rs2_phys;
    phys_reg_t [RENAME_WIDTH-1:0] rd_phys;
    phys_reg_t [RENAME_WIDTH-1:0] old_rd_phys;
    logic      [RENAME_WIDTH-1:0] rename_valid;
    logic      [RENAME_WIDTH-1:0] rename_ready;
    logic      [RENAME_WIDTH-1:0] commit_valid;
    phys_reg_t [RENAME_WIDTH-1:0] free_phys_reg;

    // Group for the next cycle, set up by the tests
    logic      [RENAME_WIDTH-1:0] nxt_valid;
    logic      [RENAME_WIDTH-1:0] nxt_we;
    arch_reg_t [RENAME_WIDTH-1:0] nxt_rs1;
    arch_reg_t [RENAME_WIDTH-1:0] nxt_rs2;
    arch_reg_t [RENAME_WIDTH-1:0] nxt_rd;
    logic      [RENAME_WIDTH-1:0] nxt_commit;
    phys_reg_t [RENAME_WIDTH-1:0] nxt_free;

    // Reference model, map table plus free queue
    int map_ref [ARCH_REGS];
    int free_q [$];
    // Displaced registers waiting for their commit
    int pending_q [$];
    bit need_ref [RENAME_WIDTH];
    bit grant_ref [RENAME_WIDTH];
    int new_ref [RENAME_WIDTH];

    int          errors;
    int          checks;
    logic [31:0] seed;

    rename_stage dut_i (
        .clk (clk), .reset (reset), .decode_valid (decode_valid),
        .rs1_arch_0 (rs1_arch[0]), .rs1_arch_1 (rs1_arch[1]), .rs1_arch_2 (rs1_arch[2]),
        .rs2_arch_0 (rs2_arch[0]), .rs2_arch_1 (rs2_arch[1]), .rs2_arch_2 (rs2_arch[2]),
        .rd_arch_0 (rd_arch[0]), .rd_arch_1 (rd_arch[1]), .rd_arch_2 (rd_arch[2]),
        .rd_write_enable_0 (rd_we[0]), .rd_write_enable_1 (rd_we[1]),
        .rd_write_enable_2 (rd_we[2]),
        .rs1_phys_0 (rs1_phys[0]), .rs1_phys_1 (rs1_phys[1]), .rs1_phys_2 (rs1_phys[2]),
        .rs2_phys_0 (rs2_phys[0]), .rs2_phys_1 (rs2_phys[1]), .rs2_phys_2 (rs2_phys[2]),
        .rd_phys_0 (rd_phys[0]), .rd_phys_1 (rd_phys[1]), .rd_phys_2 (rd_phys[2]),
        .old_rd_phys_0 (old_rd_phys[0]), .old_rd_phys_1 (old_rd_phys[1]),
        .old_rd_phys_2 (old_rd_phys[2]),
        .rename_valid (rename_valid), .rename_ready (rename_ready),
        .commit_valid (commit_valid), .free_phys_reg_0 (free_phys_reg[0]),
        .free_phys_reg_1 (free_phys_reg[1]), .free_phys_reg_2 (free_phys_reg[2])
    );

    // Free list and table checks sit next to the DUT internals
    bind rename_stage rename_stage_asserts asserts_i (
        .clk         (clk),
        .reset       (reset),
        .free_count  (free_count),
        .alloc_valid ({link[2].alloc_valid, link[1].alloc_valid, link[0].alloc_valid}),
        .alloc_phys  ({link[2].alloc_phys, link[1].alloc_phys, link[0].alloc_phys}),
        .map_zero    (map_table_i.map_mem[0])
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ==========================================================
    // Helpers
    // ==========================================================

    // 32-bit LCG
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Thermometer of the free count, at most three ones
    function automatic int ready_code(int n);
        return (n >= 3) ? 3'b111 : (n == 2) ? 3'b011 : (n == 1) ? 3'b001 : 3'b000;
    endfunction

    // Table lookup with forwarding from older granted slots
    function automatic int forward_lookup(int slot, int arch);
        int p;
        if (arch == 0) begin
            return 0;
        end
        p = map_ref[arch];
        for (int j = 0; j < slot; j++) begin
            if (grant_ref[j] && (int'(nxt_rd[j]) == arch)) begin
                p = new_ref[j];
            end
        end
        return p;
    endfunction

    task automatic check_val(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic clear_group();
        nxt_valid  = '0;
        nxt_we     = '0;
        nxt_rs1    = '0;
        nxt_rs2    = '0;
        nxt_rd     = '0;
        nxt_commit = '0;
        nxt_free   = '0;
    endtask

    task automatic set_slot(input int i, input bit v, input bit we,
                            input int rs1, input int rs2, input int rd);
        nxt_valid[i] = v;
        nxt_we[i]    = we;
        nxt_rs1[i]   = arch_reg_t'(rs1);
        nxt_rs2[i]   = arch_reg_t'(rs2);
        nxt_rd[i]    = arch_reg_t'(rd);
    endtask

    task automatic set_release(input int i, input bit v, input int p);
        nxt_commit[i] = v;
        nxt_free[i]   = phys_reg_t'(p);
    endtask

    // ==========================================================
    // One cycle: drive, compare with the model, advance the model
    // ==========================================================

    task automatic apply_cycle();
        int taken;
        int granted;
        int exp_old;
        @(posedge clk);
        decode_valid  <= nxt_valid;
        rd_we         <= nxt_we;
        rs1_arch      <= nxt_rs1;
        rs2_arch      <= nxt_rs2;
        rd_arch       <= nxt_rd;
        commit_valid  <= nxt_commit;
        free_phys_reg <= nxt_free;
        @(negedge clk);
        check_val("rename_ready", ready_code(free_q.size()), rename_ready);
        // Slot i takes the entry after all older requests
        taken   = 0;
        granted = 0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            need_ref[i]  = nxt_valid[i] && nxt_we[i] && (nxt_rd[i] != '0);
            grant_ref[i] = need_ref[i] && (taken < free_q.size());
            new_ref[i]   = grant_ref[i] ? free_q[taken] : 0;
            taken        = taken + int'(need_ref[i]);
            granted      = granted + int'(grant_ref[i]);
        end
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            exp_old = grant_ref[i] ? forward_lookup(i, nxt_rd[i]) : 0;
            check_val($sformatf("rs1_phys_%0d", i), forward_lookup(i, nxt_rs1[i]), rs1_phys[i]);
            check_val($sformatf("rs2_phys_%0d", i), forward_lookup(i, nxt_rs2[i]), rs2_phys[i]);
            check_val($sformatf("rd_phys_%0d", i), new_ref[i], rd_phys[i]);
            check_val($sformatf("old_rd_phys_%0d", i), exp_old, old_rd_phys[i]);
            check_val($sformatf("rename_valid_%0d", i),
                      need_ref[i] ? grant_ref[i] : nxt_valid[i], rename_valid[i]);
            if (grant_ref[i]) begin
                pending_q.push_back(exp_old);
            end
        end
        // Youngest write to an entry lands last
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (grant_ref[i]) begin
                map_ref[nxt_rd[i]] = new_ref[i];
            end
        end
        repeat (granted) void'(free_q.pop_front());
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (nxt_commit[i] && (nxt_free[i] != '0)) begin
                free_q.push_back(int'(nxt_free[i]));
            end
        end
    endtask

    // ==========================================================
    // Tests
    // ==========================================================

    task automatic wait_for_ready(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 50 && !ok; n++) begin
            @(negedge clk);
            ok = (reset && rename_ready == 3'b111);
        end
        if (!ok) begin
            errors++;
            $display("Timeout: rename_ready did not reach 3'b111 after reset");
        end
    endtask

    task automatic test_reset_state();
        int a [RENAME_WIDTH];
        check_val("rename_valid", 0, rename_valid);
        check_val("rename_ready", 3'b111, rename_ready);
        clear_group();
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            a[i] = int'(next_random() % 32);
            set_slot(i, 1'b1, 1'b0, a[i], 31 - a[i], 0);
        end
        apply_cycle();
        // Identity map right after reset
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            check_val($sformatf("rs1_phys_%0d", i), a[i], rs1_phys[i]);
            check_val($sformatf("rs2_phys_%0d", i), 31 - a[i], rs2_phys[i]);
        end
    endtask

    task automatic test_alloc_gaps();
        clear_group();
        set_slot(0, 1'b1, 1'b0, 1, 2, 0);
        set_slot(1, 1'b1, 1'b1, 3, 4, 5);
        set_slot(2, 1'b1, 1'b1, 6, 8, 7);
        apply_cycle();
        check_val("rd_phys_1", 32, rd_phys[1]);
        check_val("rd_phys_2", 33, rd_phys[2]);
        check_val("old_rd_phys_1", 5, old_rd_phys[1]);
        check_val("old_rd_phys_2", 7, old_rd_phys[2]);
        // Middle slot without a destination must not stall slot 2
        clear_group();
        set_slot(0, 1'b1, 1'b1, 5, 0, 9);
        set_slot(1, 1'b1, 1'b0, 7, 9, 0);
        set_slot(2, 1'b1, 1'b1, 5, 5, 5);
        apply_cycle();
        check_val("rd_phys_0", 34, rd_phys[0]);
        check_val("rd_phys_2", 35, rd_phys[2]);
        check_val("old_rd_phys_2", 32, old_rd_phys[2]);
    endtask

    task automatic test_forwarding();
        clear_group();
        set_slot(0, 1'b1, 1'b1, 1, 2, 3);
        set_slot(1, 1'b1, 1'b1, 3, 0, 0);
        set_slot(2, 1'b1, 1'b1, 3, 3, 3);
        apply_cycle();
        // Head is at 36 after the four grants before
        check_val("rd_phys_0", 36, rd_phys[0]);
        check_val("rs1_phys_1", 36, rs1_phys[1]);
        check_val("rs2_phys_1", 0, rs2_phys[1]);
        check_val("rd_phys_1", 0, rd_phys[1]);
        check_val("rename_valid_1", 1, rename_valid[1]);
        check_val("rs1_phys_2", 36, rs1_phys[2]);
        check_val("old_rd_phys_2", 36, old_rd_phys[2]);
        check_val("rd_phys_2", 37, rd_phys[2]);
    endtask

    task automatic test_exhaustion();
        bit seen_two;
        bit seen_one;
        int a;
        int b;
        seen_two = 1'b0;
        seen_one = 1'b0;
        for (int n = 0; n < 40 && free_q.size() > 0; n++) begin
            clear_group();
            for (int i = 0; i < ((free_q.size() > 3) ? 3 : 1); i++) begin
                set_slot(i, 1'b1, 1'b1, i, i + 1, int'(next_random() % 31) + 1);
            end
            apply_cycle();
            seen_two = seen_two || (rename_ready == 3'b011);
            seen_one = seen_one || (rename_ready == 3'b001);
        end
        assert (seen_two && seen_one) else begin
            errors++;
            $display("rename_ready skipped 3'b011 or 3'b001 while the queue drained");
        end
        // Empty queue, slots 0 and 1 refused, present them twice
        clear_group();
        set_slot(0, 1'b1, 1'b1, 4, 6, 4);
        set_slot(1, 1'b1, 1'b1, 4, 6, 6);
        set_slot(2, 1'b1, 1'b0, 4, 6, 0);
        apply_cycle();
        check_val("rename_ready", 0, rename_ready);
        check_val("rename_valid", 3'b100, rename_valid);
        apply_cycle();
        check_val("rename_valid", 3'b100, rename_valid);
        // Released now, usable one cycle later
        a = pending_q.pop_front();
        b = pending_q.pop_front();
        set_release(0, 1'b1, a);
        set_release(1, 1'b1, b);
        apply_cycle();
        check_val("rename_valid", 3'b100, rename_valid);
        set_release(0, 1'b0, 0);
        set_release(1, 1'b0, 0);
        apply_cycle();
        check_val("rename_valid", 3'b111, rename_valid);
        check_val("rd_phys_0", a, rd_phys[0]);
        check_val("rd_phys_1", b, rd_phys[1]);
    endtask

    task automatic test_release_reuse();
        int p [5];
        for (int i = 0; i < 5; i++) begin
            p[i] = pending_q.pop_front();
        end
        clear_group();
        set_release(0, 1'b1, p[0]);
        set_release(1, 1'b1, p[1]);
        set_release(2, 1'b1, p[2]);
        apply_cycle();
        // Phys 0 on port 1 is dropped, port 2 lands right after port 0
        clear_group();
        set_release(0, 1'b1, p[3]);
        set_release(1, 1'b1, 0);
        set_release(2, 1'b1, p[4]);
        set_slot(0, 1'b1, 1'b1, 0, 0, 8);
        apply_cycle();
        check_val("rd_phys_0", p[0], rd_phys[0]);
        clear_group();
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            set_slot(i, 1'b1, 1'b1, 8, i, 10 + i);
        end
        apply_cycle();
        check_val("rd_phys_0", p[1], rd_phys[0]);
        check_val("rd_phys_1", p[2], rd_phys[1]);
        check_val("rd_phys_2", p[3], rd_phys[2]);
        clear_group();
        set_slot(0, 1'b1, 1'b1, 10, 11, 12);
        apply_cycle();
        check_val("rd_phys_0", p[4], rd_phys[0]);
    endtask

    task automatic test_random_groups();
        logic [31:0] r;
        for (int n = 0; n < 200; n++) begin
            clear_group();
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                r = next_random();
                set_slot(i, r[31:30] != 2'b00, r[29], r[28:24], r[23:19], r[18:14]);
            end
            // Roughly one release in four per port, now and then phys 0
            r = next_random();
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (r[8*i +: 2] == 2'b11 && pending_q.size() > 0) begin
                    set_release(i, 1'b1, pending_q.pop_front());
                end else if (r[8*i + 2] && r[8*i + 3]) begin
                    set_release(i, 1'b1, 0);
                end
            end
            apply_cycle();
        end
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial begin
        bit ok;
        errors = 0;
        checks = 0;
        seed   = 32'hfe67_0760;
        reset  = 1'b0;
        clear_group();
        decode_valid  = '0;
        rd_we         = '0;
        rs1_arch      = '0;
        rs2_arch      = '0;
        rd_arch       = '0;
        commit_valid  = '0;
        free_phys_reg = '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_ref[i] = i;
            free_q.push_back(ARCH_REGS + i);
        end
        repeat (16) @(posedge clk);
        reset <= 1'b1;
        wait_for_ready(ok);
        if (ok) begin
            test_reset_state();
            test_alloc_gaps();
            test_forwarding();
            test_exhaustion();
            test_release_reuse();
            test_random_groups();
            clear_group();
            apply_cycle();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/rename_stage_asserts.sv
`timescale 1ns/100ps

module rename_stage_asserts import rename_pkg::*; (
    input  logic                               clk,
    input  logic                               reset,
    input  free_cnt_t                          free_count,
    input  logic      [RENAME_WIDTH-1:0]       alloc_valid,
    input  phys_reg_t [RENAME_WIDTH-1:0]       alloc_phys,
    input  phys_reg_t                          map_zero
);

    // ==========================================================
    // Map table
    // ==========================================================

    // x0 stays on the zero register
    map_zero_fixed: assert property (@(posedge clk) disable iff (!reset)
        map_zero == '0)
        else $error("Map entry zero moved to phys %0d", map_zero);

    // ==========================================================
    // Free list
    // ==========================================================

    // Queue never holds more than all physical registers
    free_count_range: assert property (@(posedge clk) disable iff (!reset)
        free_count <= free_cnt_t'(PHYS_REGS))
        else $error("Free count %0d above %0d", free_count, PHYS_REGS);

    for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_slot
        // Phys 0 is never handed out
        grant_not_zero: assert property (@(posedge clk) disable iff (!reset)
            alloc_valid[g] |-> (alloc_phys[g] != '0))
            else $error("Slot %0d granted phys 0", g);

        // Two slots of one group never share a register
        for (genvar k = g + 1; k < RENAME_WIDTH; k++) begin : g_younger
            grant_distinct: assert property (@(posedge clk) disable iff (!reset)
                (alloc_valid[g] && alloc_valid[k]) |->
                    (alloc_phys[g] != alloc_phys[k]))
                else $error("Slots %0d and %0d granted the same phys %0d",
                            g, k, alloc_phys[g]);
        end
    end

endmodule

// File: logic/rename_stage.sv
`timescale 1ns/100ps

module rename_stage import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,

    // Decode side
    input  logic [RENAME_WIDTH-1:0] decode_valid,
    input  arch_reg_t               rs1_arch_0,
    input  arch_reg_t               rs1_arch_1,
    input  arch_reg_t               rs1_arch_2,
    input  arch_reg_t               rs2_arch_0,
    input  arch_reg_t               rs2_arch_1,
    input  arch_reg_t               rs2_arch_2,
    input  arch_reg_t               rd_arch_0,
    input  arch_reg_t               rd_arch_1,
    input  arch_reg_t               rd_arch_2,
    input  logic                    rd_write_enable_0,
    input  logic                    rd_write_enable_1,
    input  logic                    rd_write_enable_2,

    // Rename results
    output phys_reg_t               rs1_phys_0,
    output phys_reg_t               rs1_phys_1,
    output phys_reg_t               rs1_phys_2,
    output phys_reg_t               rs2_phys_0,
    output phys_reg_t               rs2_phys_1,
    output phys_reg_t               rs2_phys_2,
    output phys_reg_t               rd_phys_0,
    output phys_reg_t               rd_phys_1,
    output phys_reg_t               rd_phys_2,
    output phys_reg_t               old_rd_phys_0,
    output phys_reg_t               old_rd_phys_1,
    output phys_reg_t               old_rd_phys_2,
    output logic [RENAME_WIDTH-1:0] rename_valid,
    output logic [RENAME_WIDTH-1:0] rename_ready,

    // Commit side, registers returned by the ROB
    input  logic [RENAME_WIDTH-1:0] commit_valid,
    input  phys_reg_t               free_phys_reg_0,
    input  phys_reg_t               free_phys_reg_1,
    input  phys_reg_t               free_phys_reg_2
);

    // ==========================================================
    // Per-slot wiring
    // ==========================================================

    arch_reg_t               slot_rs1_arch [RENAME_WIDTH];
    arch_reg_t               slot_rs2_arch [RENAME_WIDTH];
    arch_reg_t               slot_rd_arch [RENAME_WIDTH];
    logic [RENAME_WIDTH-1:0] slot_rd_we;
    phys_reg_t               slot_rd_phys [RENAME_WIDTH];
    phys_reg_t               slot_old_rd_phys [RENAME_WIDTH];
    phys_reg_t               free_phys [RENAME_WIDTH];
    free_cnt_t               free_count;

    rename_slot_if link [RENAME_WIDTH] ();

    assign slot_rs1_arch = '{rs1_arch_0, rs1_arch_1, rs1_arch_2};
    assign slot_rs2_arch = '{rs2_arch_0, rs2_arch_1, rs2_arch_2};
    assign slot_rd_arch  = '{rd_arch_0, rd_arch_1, rd_arch_2};
    assign slot_rd_we    = {rd_write_enable_2, rd_write_enable_1, rd_write_enable_0};
    assign free_phys     = '{free_phys_reg_0, free_phys_reg_1, free_phys_reg_2};

    for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_slot
        rename_slot slot_i (
            .decode_valid    (decode_valid[g]),
            .rd_write_enable (slot_rd_we[g]),
            .rs1_arch        (slot_rs1_arch[g]),
            .rs2_arch        (slot_rs2_arch[g]),
            .rd_arch         (slot_rd_arch[g]),
            .link            (link[g]),
            .rd_phys         (slot_rd_phys[g]),
            .old_rd_phys     (slot_old_rd_phys[g]),
            .rename_valid    (rename_valid[g])
        );
    end

    // Source lookups come straight from the map table
    assign rs1_phys_0    = link[0].rs1_phys;
    assign rs1_phys_1    = link[1].rs1_phys;
    assign rs1_phys_2    = link[2].rs1_phys;
    assign rs2_phys_0    = link[0].rs2_phys;
    assign rs2_phys_1    = link[1].rs2_phys;
    assign rs2_phys_2    = link[2].rs2_phys;
    assign rd_phys_0     = slot_rd_phys[0];
    assign rd_phys_1     = slot_rd_phys[1];
    assign rd_phys_2     = slot_rd_phys[2];
    assign old_rd_phys_0 = slot_old_rd_phys[0];
    assign old_rd_phys_1 = slot_old_rd_phys[1];
    assign old_rd_phys_2 = slot_old_rd_phys[2];

    // ==========================================================
    // Free list and map table
    // ==========================================================

    free_list_queue free_list_i (
        .clk          (clk),
        .reset        (reset),
        .slots        (link),
        .commit_valid (commit_valid),
        .free_phys    (free_phys),
        .free_count   (free_count)
    );

    map_table map_table_i (
        .clk   (clk),
        .reset (reset),
        .slots (link)
    );

    // Thermometer of free registers, capped at the group width
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            rename_ready[i] = (free_count > free_cnt_t'(i));
        end
    end

endmodule

// File: logic/map_table.sv
`timescale 1ns/100ps

module map_table import rename_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    rename_slot_if.map slots [RENAME_WIDTH]
);

    // ==========================================================
    // Table storage
    // ==========================================================

    // Current physical register of each architectural register
    phys_reg_t map_mem [ARCH_REGS];

    // Slot signals copied out of the interface array
    arch_reg_t rs1_a [RENAME_WIDTH];
    arch_reg_t rs2_a [RENAME_WIDTH];
    arch_reg_t rd_a [RENAME_WIDTH];
    phys_reg_t new_p [RENAME_WIDTH];
    logic [RENAME_WIDTH-1:0] grant;

    // Lookup results after forwarding
    phys_reg_t rs1_p [RENAME_WIDTH];
    phys_reg_t rs2_p [RENAME_WIDTH];
    phys_reg_t old_p [RENAME_WIDTH];

    for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_port
        assign rs1_a[g] = slots[g].rs1_arch;
        assign rs2_a[g] = slots[g].rs2_arch;
        assign rd_a[g]  = slots[g].rd_arch;
        assign new_p[g] = slots[g].alloc_phys;
        // Free list grants only slots that asked, so no second check
        assign grant[g] = slots[g].alloc_valid;

        assign slots[g].rs1_phys    = rs1_p[g];
        assign slots[g].rs2_phys    = rs2_p[g];
        assign slots[g].old_rd_phys = old_p[g];
    end

    // ==========================================================
    // Lookups with same-group forwarding
    // ==========================================================

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            // Start from the committed table contents
            rs1_p[i] = map_mem[rs1_a[i]];
            rs2_p[i] = map_mem[rs2_a[i]];
            old_p[i] = map_mem[rd_a[i]];

            // Walk older slots oldest first, so the newest match wins
            for (int j = 0; j < i; j++) begin
                if (grant[j] && (rd_a[j] == rs1_a[i])) begin
                    rs1_p[i] = new_p[j];
                end
                if (grant[j] && (rd_a[j] == rs2_a[i])) begin
                    rs2_p[i] = new_p[j];
                end
                // Older write in this group is the mapping we displace
                if (grant[j] && (rd_a[j] == rd_a[i])) begin
                    old_p[i] = new_p[j];
                end
            end
        end
    end

    // x0 needs no special case here, entry 0 stays at phys 0 and
    // a granted slot never has rd_arch 0

    // ==========================================================
    // Table update
    // ==========================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity map, arch i lives in phys i
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_mem[i] <= phys_reg_t'(i);
            end
        end else begin
            // Slot order, later writes to the same entry take effect
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (grant[i]) begin
                    map_mem[rd_a[i]] <= new_p[i];
                end
            end
        end
    end

endmodule

// File: logic/rename_slot.sv
`timescale 1ns/100ps

module rename_slot import rename_pkg::*; (
    // Decoded instruction
    input  logic       decode_valid,
    input  logic       rd_write_enable,
    input  arch_reg_t  rs1_arch,
    input  arch_reg_t  rs2_arch,
    input  arch_reg_t  rd_arch,

    // Free list and map table
    rename_slot_if.slot link,

    // Rename result of this slot
    output phys_reg_t  rd_phys,
    output phys_reg_t  old_rd_phys,
    output logic       rename_valid
);

    // ==========================================================
    // Destination qualification
    // ==========================================================

    // Writes a real register, x0 writes are dropped
    logic has_dest;

    // Needs a new physical register this cycle
    logic need_alloc;

    assign has_dest   = rd_write_enable && (rd_arch != '0);
    assign need_alloc = decode_valid && has_dest;

    // Architectural numbers go to the map table as they are
    assign link.rs1_arch   = rs1_arch;
    assign link.rs2_arch   = rs2_arch;
    assign link.rd_arch    = rd_arch;
    assign link.need_alloc = need_alloc;

    // ==========================================================
    // Slot result
    // ==========================================================

    always_comb begin
        // Default is a slot with nothing to rename
        rd_phys      = '0;
        old_rd_phys  = '0;
        rename_valid = 1'b0;

        if (need_alloc) begin
            // Done only once the free list grants a register
            rename_valid = link.alloc_valid;
            if (link.alloc_valid) begin
                rd_phys     = link.alloc_phys;
                // Mapping displaced by this write, freed at commit
                old_rd_phys = link.old_rd_phys;
            end
        end else begin
            // Sources only, or a write to x0
            rename_valid = decode_valid;
        end
    end

endmodule

// File: logic/free_list_queue.sv
`timescale 1ns/100ps

module free_list_queue import rename_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    rename_slot_if.alloc            slots [RENAME_WIDTH],
    input  logic [RENAME_WIDTH-1:0] commit_valid,
    input  phys_reg_t               free_phys [RENAME_WIDTH],
    output free_cnt_t               free_count
);

    // ==========================================================
    // Queue state
    // ==========================================================

    // Circular storage of free physical register numbers
    phys_reg_t queue_mem [PHYS_REGS];

    // Head is the oldest free entry, tail the next write slot
    queue_ptr_t head;
    queue_ptr_t tail;
    free_cnt_t  count;

    // Per-slot requests and grants
    logic [RENAME_WIDTH-1:0] req;
    logic [RENAME_WIDTH-1:0] grant_valid;
    phys_reg_t               grant_phys [RENAME_WIDTH];

    // Older requests ahead of each slot, i.e. its offset from head
    free_cnt_t  req_before [RENAME_WIDTH];
    queue_ptr_t rd_ptr [RENAME_WIDTH];
    free_cnt_t  grant_total;

    // Releases after dropping invalid ports and phys 0
    logic [RENAME_WIDTH-1:0] rel;
    free_cnt_t               rel_before [RENAME_WIDTH];
    queue_ptr_t              wr_ptr [RENAME_WIDTH];
    free_cnt_t               rel_total;

    // Interface array needs constant indices
    for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_port
        assign req[g]               = slots[g].need_alloc;
        assign slots[g].alloc_phys  = grant_phys[g];
        assign slots[g].alloc_valid = grant_valid[g];
    end

    // ==========================================================
    // Allocation, compacted over the requesting slots
    // ==========================================================

    always_comb begin
        grant_total = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            req_before[i] = '0;
            // Count only older slots that asked for a register
            for (int j = 0; j < i; j++) begin
                req_before[i] = req_before[i] + free_cnt_t'(req[j]);
            end
            rd_ptr[i]      = head + queue_ptr_t'(req_before[i]);
            grant_phys[i]  = queue_mem[rd_ptr[i]];
            // Offsets grow with slot index so refusals stay in order
            grant_valid[i] = req[i] && (req_before[i] < count);
            grant_total    = grant_total + free_cnt_t'(grant_valid[i]);
        end
    end

    // ==========================================================
    // Release, packed at the tail in port order
    // ==========================================================

    always_comb begin
        rel_total = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            // Phys 0 is the zero register and never enters the queue
            rel[i]        = commit_valid[i] && (free_phys[i] != '0);
            rel_before[i] = rel_total;
            wr_ptr[i]     = tail + queue_ptr_t'(rel_before[i]);
            rel_total     = rel_total + free_cnt_t'(rel[i]);
        end
    end

    // ==========================================================
    // State update
    // ==========================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Entries 0 to 31 hold phys 32 to 63, the rest is unused
            for (int i = 0; i < PHYS_REGS; i++) begin
                queue_mem[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= queue_ptr_t'(INIT_FREE);
            count <= free_cnt_t'(INIT_FREE);
        end else begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (rel[i]) begin
                    queue_mem[wr_ptr[i]] <= free_phys[i];
                end
            end
            // Pointers wrap at 64 on their own
            head  <= head + queue_ptr_t'(grant_total);
            tail  <= tail + queue_ptr_t'(rel_total);
            count <= count - grant_total + rel_total;
        end
    end

    assign free_count = count;

endmodule

// File: logic/rename_slot_if.sv
`timescale 1ns/100ps

interface rename_slot_if import rename_pkg::*; ();

    // Architectural numbers of the instruction in this slot
    arch_reg_t rs1_arch;
    arch_reg_t rs2_arch;
    arch_reg_t rd_arch;

    // Slot asks the free list for a new destination register
    logic      need_alloc;

    // Grant from the free list
    phys_reg_t alloc_phys;
    logic      alloc_valid;

    // Lookups from the map table, already forwarded within the group
    phys_reg_t rs1_phys;
    phys_reg_t rs2_phys;
    phys_reg_t old_rd_phys;

    // Rename slot side
    modport slot (output rs1_arch, rs2_arch, rd_arch, need_alloc,
                  input  alloc_phys, alloc_valid, old_rd_phys);

    // Free list side
    modport alloc (input  need_alloc,
                   output alloc_phys, alloc_valid);

    // Map table side
    modport map (input  rs1_arch, rs2_arch, rd_arch, alloc_phys, alloc_valid,
                 output rs1_phys, rs2_phys, old_rd_phys);

endinterface

// File: logic/rename_pkg.sv
package rename_pkg;

    // ==========================================================
    // Register file sizes
    // ==========================================================

    // Architectural registers x0 to x31
    localparam int ARCH_REGS = 32;

    // Physical registers, phys 0 is the hardwired zero
    localparam int PHYS_REGS = 64;

    // Instructions renamed per cycle
    localparam int RENAME_WIDTH = 3;

    // Registers in the free queue after reset
    localparam int INIT_FREE = PHYS_REGS - ARCH_REGS;

    // Derived widths
    localparam int ARCH_W = $clog2(ARCH_REGS);
    localparam int PHYS_W = $clog2(PHYS_REGS);

    // ==========================================================
    // Register number types
    // ==========================================================

    typedef logic [ARCH_W-1:0] arch_reg_t;
    typedef logic [PHYS_W-1:0] phys_reg_t;

    // One extra bit so that a full queue (64) fits
    typedef logic [PHYS_W:0] free_cnt_t;

    // Index into the free queue storage
    typedef logic [PHYS_W-1:0] queue_ptr_t;

endpackage
